// File: Bender.yml
package:
  name: hamming_link

sources:
  # shared package first
  - source/hamming_pkg.sv
  - source/hamming_encoder.sv
  - source/hamming_decoder.sv
  - source/hamming_link.sv

  - target: simulation
    files:
      - tb/hamming_link_props.sv
      - tb/hamming_link_tb.sv

  - target: test
    files:
      - tb/hamming_link_props.sv
      - tb/hamming_link_tb.sv

# top modules
# rtl: hamming_link
# testbench: hamming_link_tb

// File: compile.f
source/hamming_pkg.sv
source/hamming_encoder.sv
source/hamming_decoder.sv
source/hamming_link.sv
tb/hamming_link_props.sv
tb/hamming_link_tb.sv

// File: source/hamming_decoder.sv
// hamming_decoder with syndrome check, single-bit correction, output register and corrected-error count
`default_nettype none

module hamming_decoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cw_valid,
    output logic                          cw_ready,
    input  hamming_pkg::codeword_t        cw,
    output logic                          out_valid,
    input  logic                          out_ready,
    output hamming_pkg::dec_result_t      out_res,
    output logic [hamming_pkg::cnt_w-1:0] corrected_count
);
    import hamming_pkg::*;

    logic [data_w-1:0] rx_data;    // data bits as received
    logic [pos_w-1:0]  rx_parity;  // parity bits as received
    logic [pos_w-1:0]  syndrome;
    logic              has_error;
    codeword_t         fix_mask;
    codeword_t         fixed_cw;
    dec_result_t       res_next;
    logic              load;

    // the single output slot may refill on the edge it drains
    assign cw_ready = !out_valid || out_ready;
    assign load     = cw_valid && cw_ready;

    always_comb begin
        rx_data   = get_data(cw);
        rx_parity = {cw[pos_p4], cw[pos_p2], cw[pos_p1]};
    end

    // recomputed parity against received parity
    // the result reads directly as the faulty bit index plus one
    assign syndrome  = calc_parity(rx_data) ^ rx_parity;
    assign has_error = (syndrome != '0);

    always_comb begin
        fix_mask = '0;
        if (has_error) begin
            fix_mask = codeword_t'(1) << (syndrome - pos_w'(1));
        end
    end

    assign fixed_cw = cw ^ fix_mask;

    always_comb begin
        res_next.data      = get_data(fixed_cw);
        res_next.syndrome  = syndrome;
        res_next.corrected = has_error;  // parity bit hits count too
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid       <= 1'b0;
            corrected_count <= '0;
        end else begin
            if (load) begin
                out_valid <= 1'b1;
                if (has_error) begin
                    corrected_count <= corrected_count + cnt_w'(1);
                end
            end else if (out_ready) begin
                out_valid <= 1'b0;  // drained with nothing behind it
            end
        end
    end

    // result register
    always_ff @(posedge clk) begin
        if (load) begin
            out_res <= res_next;
        end
    end

endmodule

`default_nettype wire

// File: source/hamming_encoder.sv
// hamming_encoder with three-state handshake control, one-bit fault injection and injected-error count
`default_nettype none

module hamming_encoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  hamming_pkg::enc_req_t         in_req,
    output logic                          cw_valid,
    input  logic                          cw_ready,
    output hamming_pkg::codeword_t        cw,
    output logic [hamming_pkg::cnt_w-1:0] injected_count
);
    import hamming_pkg::*;

    enc_state_t       state;
    enc_state_t       next_state;
    enc_req_t         req_q;       // request held from acceptance on
    logic [pos_w-1:0] parity;
    codeword_t        cw_clean;    // codeword before fault injection
    codeword_t        flip_mask;
    logic             inject_hit;
    logic             accept;
    logic             handoff;

    assign in_ready = (state == IDLE);
    assign accept   = in_valid && in_ready;
    assign handoff  = cw_valid && cw_ready;

    // only positions inside the codeword are flipped
    assign inject_hit = req_q.inject && (req_q.inject_pos < pos_w'(code_w));

    always_comb begin
        parity           = calc_parity(req_q.data);
        cw_clean         = '0;
        cw_clean[pos_p1] = parity[0];
        cw_clean[pos_p2] = parity[1];
        cw_clean[pos_p4] = parity[2];
        cw_clean[pos_d0] = req_q.data[0];
        cw_clean[pos_d1] = req_q.data[1];
        cw_clean[pos_d2] = req_q.data[2];
        cw_clean[pos_d3] = req_q.data[3];
    end

    always_comb begin
        flip_mask = '0;
        if (inject_hit) begin
            flip_mask = codeword_t'(1) << req_q.inject_pos;  // one-hot at the chosen bit
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (in_valid) begin
                    next_state = PROCESSING;
                end
            end
            PROCESSING: begin
                next_state = WAITING;
            end
            WAITING: begin
                if (handoff) begin
                    next_state = IDLE;  // codeword taken by the decoder
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= IDLE;
            cw_valid       <= 1'b0;
            injected_count <= '0;
        end else begin
            state <= next_state;
            if (state == PROCESSING) begin
                cw_valid <= 1'b1;
                if (inject_hit) begin
                    injected_count <= injected_count + cnt_w'(1);
                end
            end else if (handoff) begin
                cw_valid <= 1'b0;
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= in_req;
        end
        if (state == PROCESSING) begin
            cw <= cw_clean ^ flip_mask;
        end
    end

endmodule

`default_nettype wire

// File: source/hamming_link.sv
// hamming_link top level joining the encoder to the decoder over a valid/ready codeword link
`default_nettype none

module hamming_link (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  hamming_pkg::enc_req_t         in_req,
    output logic                          out_valid,
    input  logic                          out_ready,
    output hamming_pkg::dec_result_t      out_res,
    output logic [hamming_pkg::cnt_w-1:0] injected_count,
    output logic [hamming_pkg::cnt_w-1:0] corrected_count
);
    import hamming_pkg::*;

    // codeword link between the two stages
    logic      cw_valid;
    logic      cw_ready;
    codeword_t cw;

    hamming_encoder i_hamming_encoder (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_req         (in_req),
        .cw_valid       (cw_valid),
        .cw_ready       (cw_ready),
        .cw             (cw),
        .injected_count (injected_count)
    );

    // faults are injected upstream so the decoder sees them on cw
    hamming_decoder i_hamming_decoder (
        .clk             (clk),
        .rst             (rst),
        .cw_valid        (cw_valid),
        .cw_ready        (cw_ready),
        .cw              (cw),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_res         (out_res),
        .corrected_count (corrected_count)
    );

endmodule

`default_nettype wire

// File: source/hamming_pkg.sv
// hamming_pkg with code widths, codeword bit positions, request and result structs, encoder states
`default_nettype none

package hamming_pkg;

    localparam int data_w = 4;  // payload bits per word
    localparam int code_w = 7;  // bits per codeword
    localparam int pos_w  = 3;  // bit index or syndrome
    localparam int cnt_w  = 8;  // error counter width

    // where each bit sits inside the codeword
    localparam int pos_p1 = 0;
    localparam int pos_p2 = 1;
    localparam int pos_d0 = 2;
    localparam int pos_p4 = 3;
    localparam int pos_d1 = 4;
    localparam int pos_d2 = 5;
    localparam int pos_d3 = 6;

    typedef logic [code_w-1:0] codeword_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic              inject;      // flip one codeword bit
        logic [pos_w-1:0]  inject_pos;  // 7 means no flip
    } enc_req_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [pos_w-1:0]  syndrome;    // faulty bit index plus one
        logic              corrected;
    } dec_result_t;

    typedef enum logic [1:0] {
        IDLE       = 2'b00,
        PROCESSING = 2'b01,
        WAITING    = 2'b10
    } enc_state_t;

    // parity over the data bits, ordered as the syndrome is
    // bit 0 covers p1, bit 1 covers p2, bit 2 covers p4
    function automatic logic [pos_w-1:0] calc_parity(input logic [data_w-1:0] d);
        logic [pos_w-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3];
        p[1] = d[0] ^ d[2] ^ d[3];
        p[2] = d[1] ^ d[2] ^ d[3];
        return p;
    endfunction

    // pull the four data bits out of a codeword
    function automatic logic [data_w-1:0] get_data(input codeword_t c);
        logic [data_w-1:0] d;
        d[0] = c[pos_d0];
        d[1] = c[pos_d1];
        d[2] = c[pos_d2];
        d[3] = c[pos_d3];
        return d;
    endfunction

endpackage

`default_nettype wire

// File: tb/hamming_link_props.sv
// hamming_link_props with reset, output stability and input handshake assertions
`default_nettype none

module hamming_link_props (
    input logic                          clk,
    input logic                          rst,
    input logic                          in_valid,
    input logic                          in_ready,
    input logic                          out_valid,
    input logic                          out_ready,
    input hamming_pkg::dec_result_t      out_res,
    input logic [hamming_pkg::cnt_w-1:0] injected_count,
    input logic [hamming_pkg::cnt_w-1:0] corrected_count
);

    int assert_errors = 0;  // read by the testbench at the end

    // state one cycle into or after reset
    reset_values: assert property (@(posedge clk)
        rst |=> in_ready && !out_valid && injected_count == '0 && corrected_count == '0)
    else begin
        $error("outputs not at reset values after reset");
        assert_errors++;
    end

    // stalled result must not move
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_res))
    else begin
        $error("out_valid or out_res changed while out_ready was low");
        assert_errors++;
    end

    // encoder busy for processing and at least one wait cycle
    in_busy: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready |=> !in_ready [*2])
    else begin
        $error("in_ready high within two cycles of an accepted request");
        assert_errors++;
    end

endmodule

`default_nettype wire

// File: tb/hamming_link_tb.sv
// hamming_link_tb with clock, reset, stimulus table, lfsr back-pressure, compare tasks and watchdog
`default_nettype none

module hamming_link_tb;
    import hamming_pkg::*;

    localparam int num_entries = 20;
    localparam int clk_period  = 20;
    localparam int rst_cycles  = 5;
    localparam int timeout     = (num_entries * 10 + rst_cycles) * clk_period;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    logic                 in_ready;
    enc_req_t             in_req;
    logic                 out_valid;
    logic                 out_ready;
    dec_result_t          out_res;
    logic [cnt_w-1:0]     injected_count;
    logic [cnt_w-1:0]     corrected_count;

    // stimulus table and expected results
    string                tab_name [num_entries];
    enc_req_t             tab_req  [num_entries];
    dec_result_t          tab_exp  [num_entries];
    logic [cnt_w-1:0]     exp_flips;  // entries that really flip a bit
    int                   n_loaded;
    int                   rx_count;
    int                   result_errors;
    int                   counter_errors;
    int                   other_errors;
    logic [31:0]          lfsr;

    hamming_link i_hamming_link (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_req          (in_req),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_res         (out_res),
        .injected_count  (injected_count),
        .corrected_count (corrected_count)
    );

    bind hamming_link hamming_link_props i_props (.*);

    // a flip happens only for inject with a position inside the codeword
    function automatic logic flips_bit(input enc_req_t r);
        return r.inject && (r.inject_pos != 3'd7);
    endfunction

    function automatic dec_result_t expected_result(input enc_req_t r);
        dec_result_t e;
        e.data      = r.data;
        e.syndrome  = flips_bit(r) ? r.inject_pos + 3'd1 : 3'd0;
        e.corrected = (e.syndrome != 3'd0);
        return e;
    endfunction

    // 32-bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic add_entry(input string name, input logic [3:0] data,
                             input logic inject, input logic [2:0] pos);
        tab_name[n_loaded]           = name;
        tab_req[n_loaded].data       = data;
        tab_req[n_loaded].inject     = inject;
        tab_req[n_loaded].inject_pos = pos;
        tab_exp[n_loaded]            = expected_result(tab_req[n_loaded]);
        if (flips_bit(tab_req[n_loaded])) begin
            exp_flips = exp_flips + 1'b1;
        end
        n_loaded++;
    endtask

    task automatic load_table();
        add_entry("flip_p1_d0",   4'h0, 1'b1, 3'd0);
        add_entry("flip_p2_d1",   4'h1, 1'b1, 3'd1);
        add_entry("flip_d0_d2",   4'h2, 1'b1, 3'd2);
        add_entry("flip_p4_d3",   4'h3, 1'b1, 3'd3);
        add_entry("flip_d1_d4",   4'h4, 1'b1, 3'd4);
        add_entry("flip_d2_d5",   4'h5, 1'b1, 3'd5);
        add_entry("flip_d3_d6",   4'h6, 1'b1, 3'd6);
        add_entry("pos7_d7",      4'h7, 1'b1, 3'd7);  // inject set, nothing flipped
        add_entry("clean_d8",     4'h8, 1'b0, 3'd0);
        add_entry("clean_d9",     4'h9, 1'b0, 3'd3);
        add_entry("clean_da",     4'ha, 1'b0, 3'd6);
        add_entry("clean_db",     4'hb, 1'b0, 3'd7);
        add_entry("flip_d3_dc",   4'hc, 1'b1, 3'd6);
        add_entry("flip_d0_dd",   4'hd, 1'b1, 3'd2);
        add_entry("flip_p1_de",   4'he, 1'b1, 3'd0);
        add_entry("flip_d1_df",   4'hf, 1'b1, 3'd4);
        add_entry("clean_df",     4'hf, 1'b0, 3'd0);
        add_entry("clean_d0",     4'h0, 1'b0, 3'd0);
        add_entry("pos7_d5",      4'h5, 1'b1, 3'd7);
        add_entry("flip_d2_da",   4'ha, 1'b1, 3'd5);
    endtask

    task automatic check_result(input string name, input dec_result_t exp,
                                input dec_result_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h/%0d/%b, actual %h/%0d/%b (data/syndrome/corrected)",
                     name, exp.data, exp.syndrome, exp.corrected,
                     act.data, act.syndrome, act.corrected);
            result_errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [cnt_w-1:0] exp,
                               input logic [cnt_w-1:0] act);
        if (act !== exp) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            counter_errors++;
        end
    endtask

    // one request per entry, held until in_ready takes it
    task automatic drive_all();
        for (int i = 0; i < num_entries; i++) begin
            in_valid <= 1'b1;
            in_req   <= tab_req[i];
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // back-pressure, low when both bits taken are set
    initial begin
        logic b0;
        logic b1;
        wait (!rst);
        forever begin
            @(posedge clk);
            lfsr = lfsr_next(lfsr);
            b0   = lfsr[0];
            lfsr = lfsr_next(lfsr);
            b1   = lfsr[0];
            out_ready <= !(b0 && b1);
        end
    end

    // results in table order
    initial begin
        forever begin
            @(posedge clk);
            if (!rst && out_valid && out_ready) begin
                if (rx_count < num_entries) begin
                    check_result(tab_name[rx_count], tab_exp[rx_count], out_res);
                end else begin
                    $display("extra result after the last table entry");
                    other_errors++;
                end
                rx_count++;
            end
        end
    end

    initial begin
        #(timeout);
        $display("timeout with %0d of %0d results received", rx_count, num_entries);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_req         = '0;
        out_ready      = 1'b0;
        lfsr           = 32'h2f8d;
        exp_flips      = '0;
        n_loaded       = 0;
        rx_count       = 0;
        result_errors  = 0;
        counter_errors = 0;
        other_errors   = 0;
        load_table();
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        drive_all();
        wait (rx_count == num_entries);
        repeat (4) @(posedge clk);  // room for a stray extra result
        check_count("injected_count", exp_flips, injected_count);
        check_count("corrected_count", exp_flips, corrected_count);
        if (i_hamming_link.i_props.assert_errors != 0) begin
            $display("%0d assertion failures in the bound checker",
                     i_hamming_link.i_props.assert_errors);
            other_errors += i_hamming_link.i_props.assert_errors;
        end
        $display("errors: results %0d, counters %0d, other %0d",
                 result_errors, counter_errors, other_errors);
        if (result_errors + counter_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
